// ==== Makefile ====
# Verilator build and run of the AIB to AXI-Lite follower bridge testbench

BUILD = build
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator from all.f, run into $(LOG), fail on RESULT: FAIL"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --top-module tb_aib_axi_follower \
		-Mdir $(BUILD) -f all.f
	./$(BUILD)/Vtb_aib_axi_follower > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== all.f ====
hdl/bridge_pkg.sv
hdl/flit_decoder.sv
hdl/req_fifo.sv
hdl/axil_master.sv
hdl/aib_axi_follower_top.sv
bench/axil_mem_model.sv
bench/tb_aib_axi_follower.sv

// ==== bench/axil_mem_model.sv ====
// AXI-Lite memory slave model with strobed writes, error range and random ready and valid delays
`timescale 1ns/10ps

module axil_mem_model (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  bridge_pkg::axil_req_t i_axil,
    output bridge_pkg::axil_rsp_t o_axil
);

    logic [31:0] mem [64];        // Byte addresses 0 to 255
    logic [31:0] aw_addr;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic [31:0] ar_addr;
    logic        aw_done;
    logic        w_done;
    logic        ar_done;
    int          aw_wait;
    int          w_wait;
    int          ar_wait;
    int          b_wait;
    int          r_wait;
    integer      seed = 36;

    // Fill depends on the byte address of each word
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hc0de_0000 | (i * 4) | ((i * 4) << 8);
        end
    end

    // **************************************************
    // Channel handling
    // **************************************************
    always @(posedge i_clk) begin
        if (i_rst) begin
            o_axil  <= '0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
            aw_wait <= 0;
            w_wait  <= 0;
            ar_wait <= 0;
            b_wait  <= 0;
            r_wait  <= 0;
        end else begin
            // AW channel
            if (o_axil.awready && i_axil.awvalid) begin
                aw_addr        <= i_axil.awaddr;
                aw_done        <= 1'b1;
                o_axil.awready <= 1'b0;
                aw_wait        <= $unsigned($random(seed)) % 6;
            end else if (i_axil.awvalid && !aw_done && !o_axil.awready) begin
                if (aw_wait == 0) o_axil.awready <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end
            // W channel
            if (o_axil.wready && i_axil.wvalid) begin
                w_data        <= i_axil.wdata;
                w_strb        <= i_axil.wstrb;
                w_done        <= 1'b1;
                o_axil.wready <= 1'b0;
                w_wait        <= $unsigned($random(seed)) % 6;
            end else if (i_axil.wvalid && !w_done && !o_axil.wready) begin
                if (w_wait == 0) o_axil.wready <= 1'b1;
                else w_wait <= w_wait - 1;
            end
            // B channel, memory updated when the response is issued
            if (o_axil.bvalid && i_axil.bready) begin
                o_axil.bvalid <= 1'b0;
                aw_done       <= 1'b0;
                w_done        <= 1'b0;
                b_wait        <= $unsigned($random(seed)) % 6;
            end else if (aw_done && w_done && !o_axil.bvalid) begin
                if (b_wait == 0) begin
                    o_axil.bvalid <= 1'b1;
                    if (aw_addr < 32'd256) begin
                        o_axil.bresp <= bridge_pkg::RESP_OKAY;
                        for (int b = 0; b < 4; b++) begin
                            if (w_strb[b]) mem[aw_addr[7:2]][8*b +: 8] <= w_data[8*b +: 8];
                        end
                    end else begin
                        o_axil.bresp <= bridge_pkg::RESP_SLVERR;
                    end
                end else begin
                    b_wait <= b_wait - 1;
                end
            end
            // AR channel
            if (o_axil.arready && i_axil.arvalid) begin
                ar_addr        <= i_axil.araddr;
                ar_done        <= 1'b1;
                o_axil.arready <= 1'b0;
                ar_wait        <= $unsigned($random(seed)) % 6;
            end else if (i_axil.arvalid && !ar_done && !o_axil.arready) begin
                if (ar_wait == 0) o_axil.arready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            // R channel
            if (o_axil.rvalid && i_axil.rready) begin
                o_axil.rvalid <= 1'b0;
                ar_done       <= 1'b0;
                r_wait        <= $unsigned($random(seed)) % 6;
            end else if (ar_done && !o_axil.rvalid) begin
                if (r_wait == 0) begin
                    o_axil.rvalid <= 1'b1;
                    o_axil.rdata  <= (ar_addr < 32'd256) ? mem[ar_addr[7:2]] : 32'h0;
                    o_axil.rresp  <= (ar_addr < 32'd256) ? bridge_pkg::RESP_OKAY
                                                         : bridge_pkg::RESP_SLVERR;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
        end
    end

endmodule

// ==== bench/tb_aib_axi_follower.sv ====
// Testbench for the AIB to AXI-Lite follower bridge with credit stimulus, reference model and checker
`timescale 1ns/10ps

module tb_aib_axi_follower;

    localparam int FIFO_DEPTH = 4;

    logic                              clk;
    logic                              rst;
    bridge_pkg::rx_flit_t              rx_flit;
    logic [bridge_pkg::SL_SSR_LEN-1:0] sl_sb;
    logic [bridge_pkg::MS_SSR_LEN-1:0] ms_sb;
    bridge_pkg::tx_flit_t              tx_flit;
    bridge_pkg::axil_req_t             axil_req;
    bridge_pkg::axil_rsp_t             axil_rsp;

    bridge_pkg::tx_flit_t exp_q [$];   // Expected responses in order
    logic [31:0] shadow [64];
    int     credits = FIFO_DEPTH;
    int     errors = 0;
    int     sent = 0;
    int     kept = 0;
    int     resp_cnt = 0;
    int     cycles = 0;
    integer seed = 36;

    aib_axi_follower_top #(.FIFO_DEPTH(FIFO_DEPTH)) i_aib_axi_follower_top (
        .i_clk_wr (clk), .i_rst (rst), .i_rx_flit (rx_flit),
        .i_sl_sideband (sl_sb), .i_ms_sideband (ms_sb),
        .o_tx_flit (tx_flit), .o_axil (axil_req), .i_axil (axil_rsp)
    );

    axil_mem_model i_mem (.i_clk (clk), .i_rst (rst), .i_axil (axil_req), .o_axil (axil_rsp));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reference response, shadow memory updated in request order
    function automatic bridge_pkg::tx_flit_t expect_rsp(input logic wr, input logic [3:0] strb,
                                                        input logic [31:0] addr,
                                                        input logic [31:0] data);
        bridge_pkg::tx_flit_t t;
        t        = '0;
        t.opcode = wr ? bridge_pkg::OP_WR_RESP : bridge_pkg::OP_RD_RESP;
        if (addr >= 32'd256) begin
            t.resp = bridge_pkg::RESP_SLVERR;   // Read data stays zero
        end else begin
            t.resp = bridge_pkg::RESP_OKAY;
            for (int b = 0; b < 4; b++) begin
                if (wr && strb[b]) shadow[addr[7:2]][8*b +: 8] = data[8*b +: 8];
            end
            if (!wr) t.rdata = shadow[addr[7:2]];
        end
        return t;
    endfunction

    // One word from the far side, called 2 ns after a rising edge
    task automatic send_req(input logic wr, input logic [3:0] strb, input logic [31:0] addr,
                            input logic [31:0] data);
        while (credits == 0) begin
            @(posedge clk);
            #2;
        end
        rx_flit        = '0;
        rx_flit.opcode = wr ? bridge_pkg::OP_WRITE : bridge_pkg::OP_READ;
        rx_flit.strb   = strb;
        rx_flit.addr   = addr;
        rx_flit.wdata  = data;
        credits--;
        sent++;
        if (sl_sb[bridge_pkg::SL_TX_XFER_EN_BIT] && ms_sb[bridge_pkg::MS_TX_XFER_EN_BIT]) begin
            exp_q.push_back(expect_rsp(wr, strb, addr, data));
            kept++;
        end else begin
            credits++;   // Dropped word, far side refunds itself
        end
        @(posedge clk);
        #2;
        rx_flit = '0;
    endtask

    // **************************************************
    // Compare process, outputs sampled on the falling edge
    // **************************************************
    always @(negedge clk) begin
        bridge_pkg::tx_flit_t e;
        if (!rst && tx_flit.opcode != bridge_pkg::OP_IDLE) begin
            resp_cnt++;
            assert (credits < FIFO_DEPTH) else begin
                errors++;
                $display("Response word arrived with no request outstanding");
            end
            credits++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Unexpected response word with empty expected queue");
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (tx_flit.opcode == e.opcode) else begin
                    errors++;
                    $display("MISMATCH o_tx_flit.opcode got %h exp %h", tx_flit.opcode, e.opcode);
                end
                assert (tx_flit.resp == e.resp) else begin
                    errors++;
                    $display("MISMATCH o_tx_flit.resp got %h exp %h", tx_flit.resp, e.resp);
                end
                assert (tx_flit.rdata == e.rdata) else begin
                    errors++;
                    $display("MISMATCH o_tx_flit.rdata got %h exp %h", tx_flit.rdata, e.rdata);
                end
                assert (tx_flit.pad == e.pad) else begin
                    errors++;
                    $display("MISMATCH o_tx_flit.pad got %h exp %h", tx_flit.pad, e.pad);
                end
            end
        end
    end

    // Watchdog, 40 cycles per request plus reset margin
    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * sent + 100) begin
            $display("Timeout after %0d cycles with %0d responses pending", cycles, exp_q.size());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // **************************************************
    // Stimulus
    // **************************************************
    initial begin
        for (int i = 0; i < 64; i++) begin
            shadow[i] = 32'hc0de_0000 | (i * 4) | ((i * 4) << 8);   // Same fill as the model
        end
        rst     = 1'b1;
        rx_flit = '0;
        sl_sb   = '1;
        ms_sb   = '1;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        assert (tx_flit.opcode == bridge_pkg::OP_IDLE && !axil_req.awvalid && !axil_req.wvalid
                && !axil_req.arvalid && !axil_req.bready && !axil_req.rready) else begin
            errors++;
            $display("Outputs not idle after reset");
        end
        @(posedge clk);
        #2;
        // Strobed writes, then read back
        for (int i = 0; i < 8; i++) send_req(1'b1, 4'(i + 3), 32'(i * 8), 32'h1111_1111 * (i + 1));
        for (int i = 0; i < 8; i++) send_req(1'b0, 4'hf, 32'(i * 8), 32'h0);
        // Error range
        send_req(1'b1, 4'hf, 32'h100, 32'hdead_beef);
        send_req(1'b0, 4'hf, 32'h1000_0040, 32'h0);
        // Offline on each side in turn, nothing kept
        sl_sb[bridge_pkg::SL_TX_XFER_EN_BIT] = 1'b0;
        send_req(1'b1, 4'hf, 32'h10, 32'hbad0_0001);
        sl_sb[bridge_pkg::SL_TX_XFER_EN_BIT] = 1'b1;
        ms_sb[bridge_pkg::MS_TX_XFER_EN_BIT] = 1'b0;
        send_req(1'b1, 4'hf, 32'h20, 32'hbad0_0002);
        ms_sb[bridge_pkg::MS_TX_XFER_EN_BIT] = 1'b1;
        send_req(1'b0, 4'hf, 32'h10, 32'h0);
        send_req(1'b0, 4'hf, 32'h20, 32'h0);
        // Random traffic at full credit rate
        for (int i = 0; i < 200; i++) begin
            send_req(1'($random(seed)), 4'($random(seed)),
                     (($random(seed) & 7) == 0) ? 32'h100 + ($random(seed) & 32'hff0)
                                                : 32'($random(seed) & 8'hfc),
                     $random(seed));
        end
        while (exp_q.size() != 0) @(posedge clk);
        @(negedge clk);
        assert (credits == FIFO_DEPTH && resp_cnt == kept) else begin
            errors++;
            $display("Credit or response count wrong at end of run");
        end
        $display("errors=%0d responses=%0d kept=%0d sent=%0d", errors, resp_cnt, kept, sent);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/aib_axi_follower_top.sv ====
// Top level of the AIB to AXI-Lite follower bridge with decoder, request queue and AXI engine
`timescale 1ns/10ps

module aib_axi_follower_top #(
    parameter int FIFO_DEPTH = 4   // Also the far side's starting credit
) (
    input  logic                               i_clk_wr,
    input  logic                               i_rst,
    input  bridge_pkg::rx_flit_t               i_rx_flit,
    input  logic [bridge_pkg::SL_SSR_LEN-1:0]  i_sl_sideband,
    input  logic [bridge_pkg::MS_SSR_LEN-1:0]  i_ms_sideband,
    output bridge_pkg::tx_flit_t               o_tx_flit,
    output bridge_pkg::axil_req_t              o_axil,
    input  bridge_pkg::axil_rsp_t              i_axil
);

    // **************************************************
    // Internal links
    // **************************************************
    logic             push;        // Decoder to queue
    bridge_pkg::req_t dec_req;
    logic             pop;         // Engine to queue
    bridge_pkg::req_t head_req;
    logic             not_empty;

    // Producer
    flit_decoder i_flit_decoder (
        .i_clk_wr      (i_clk_wr),
        .i_rst         (i_rst),
        .i_rx_flit     (i_rx_flit),
        .i_sl_sideband (i_sl_sideband),
        .i_ms_sideband (i_ms_sideband),
        .o_push        (push),
        .o_req         (dec_req)
    );

    // Buffer
    req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_req_fifo (
        .i_clk_wr    (i_clk_wr),
        .i_rst       (i_rst),
        .i_push      (push),
        .i_pop       (pop),
        .i_req       (dec_req),
        .o_req       (head_req),
        .o_not_empty (not_empty)
    );

    // Consumer
    axil_master i_axil_master (
        .i_clk_wr    (i_clk_wr),
        .i_rst       (i_rst),
        .i_not_empty (not_empty),
        .i_req       (head_req),
        .o_pop       (pop),
        .o_axil      (o_axil),
        .i_axil      (i_axil),
        .o_tx_flit   (o_tx_flit)
    );

endmodule

// ==== hdl/axil_master.sv ====
// AXI-Lite transaction engine for queued requests and transmit response word encoder
`timescale 1ns/10ps

module axil_master (
    input  logic                  i_clk_wr,
    input  logic                  i_rst,
    input  logic                  i_not_empty,   // Request waiting at FIFO head
    input  bridge_pkg::req_t      i_req,
    output logic                  o_pop,
    output bridge_pkg::axil_req_t o_axil,
    input  bridge_pkg::axil_rsp_t i_axil,
    output bridge_pkg::tx_flit_t  o_tx_flit      // Completion toward far side
);

    typedef enum logic [2:0] {
        ST_IDLE,    // Wait for a request
        ST_WRITE,   // AW and W in flight
        ST_WRESP,   // Wait for B
        ST_READ,    // AR in flight
        ST_RRESP    // Wait for R
    } state_e;

    state_e state_q;

    // Channel control
    logic awvalid_q;
    logic wvalid_q;
    logic arvalid_q;
    logic bready_q;
    logic rready_q;

    // Request payload held for the transaction
    logic [bridge_pkg::ADDR_W-1:0] addr_q;
    logic [bridge_pkg::DATA_W-1:0] wdata_q;
    logic [bridge_pkg::STRB_W-1:0] wstrb_q;

    // Response word fields
    bridge_pkg::opcode_e           tx_op_q;
    bridge_pkg::axi_resp_e         tx_resp_q;
    logic [bridge_pkg::DATA_W-1:0] tx_rdata_q;

    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic b_hs;
    logic r_hs;

    assign aw_hs = awvalid_q & i_axil.awready;
    assign w_hs  = wvalid_q & i_axil.wready;
    assign ar_hs = arvalid_q & i_axil.arready;
    assign b_hs  = bready_q & i_axil.bvalid;
    assign r_hs  = rready_q & i_axil.rvalid;

    assign o_pop = (state_q == ST_IDLE) & i_not_empty;   // Launch takes the head

    // **************************************************
    // Transaction FSM
    // **************************************************
    always_ff @(posedge i_clk_wr) begin
        if (i_rst) begin
            state_q   <= ST_IDLE;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            arvalid_q <= 1'b0;
            bready_q  <= 1'b0;
            rready_q  <= 1'b0;
            tx_op_q   <= bridge_pkg::OP_IDLE;
        end else begin
            tx_op_q <= bridge_pkg::OP_IDLE;   // Response lasts one cycle
            case (state_q)
                ST_IDLE: begin
                    if (i_not_empty) begin
                        if (i_req.write) begin
                            awvalid_q <= 1'b1;   // Address and data together
                            wvalid_q  <= 1'b1;
                            state_q   <= ST_WRITE;
                        end else begin
                            arvalid_q <= 1'b1;
                            state_q   <= ST_READ;
                        end
                    end
                end
                ST_WRITE: begin
                    if (aw_hs) awvalid_q <= 1'b0;   // Each channel retires on its own
                    if (w_hs)  wvalid_q  <= 1'b0;
                    if ((aw_hs || !awvalid_q) && (w_hs || !wvalid_q)) begin
                        bready_q <= 1'b1;
                        state_q  <= ST_WRESP;
                    end
                end
                ST_WRESP: begin
                    if (b_hs) begin
                        bready_q <= 1'b0;
                        tx_op_q  <= bridge_pkg::OP_WR_RESP;
                        state_q  <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (ar_hs) begin
                        arvalid_q <= 1'b0;
                        rready_q  <= 1'b1;
                        state_q   <= ST_RRESP;
                    end
                end
                ST_RRESP: begin
                    if (r_hs) begin
                        rready_q <= 1'b0;
                        tx_op_q  <= bridge_pkg::OP_RD_RESP;
                        state_q  <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Payload capture at launch
    always_ff @(posedge i_clk_wr) begin
        if (o_pop) begin
            addr_q  <= i_req.addr;
            wdata_q <= i_req.data;
            wstrb_q <= i_req.strb;
        end
    end

    // Completion capture on B or R
    always_ff @(posedge i_clk_wr) begin
        if (b_hs) begin
            tx_resp_q  <= i_axil.bresp;
            tx_rdata_q <= '0;
        end else if (r_hs) begin
            tx_resp_q  <= i_axil.rresp;
            tx_rdata_q <= i_axil.rdata;
        end
    end

    // **************************************************
    // Outputs
    // **************************************************
    assign o_axil.awaddr  = addr_q;   // One address register for both channels
    assign o_axil.awvalid = awvalid_q;
    assign o_axil.araddr  = addr_q;
    assign o_axil.arvalid = arvalid_q;
    assign o_axil.wdata   = wdata_q;
    assign o_axil.wstrb   = wstrb_q;
    assign o_axil.wvalid  = wvalid_q;
    assign o_axil.bready  = bready_q;
    assign o_axil.rready  = rready_q;

    assign o_tx_flit.opcode = tx_op_q;
    assign o_tx_flit.resp   = tx_resp_q;
    assign o_tx_flit.rdata  = tx_rdata_q;
    assign o_tx_flit.pad    = '0;

    // Payload must not move while a valid waits for ready
    a_aw_stable: assert property (@(posedge i_clk_wr) disable iff (i_rst)
        awvalid_q && !i_axil.awready |=> awvalid_q && $stable(addr_q));

    a_w_stable: assert property (@(posedge i_clk_wr) disable iff (i_rst)
        wvalid_q && !i_axil.wready |=> wvalid_q && $stable(wdata_q) && $stable(wstrb_q));

    a_ar_stable: assert property (@(posedge i_clk_wr) disable iff (i_rst)
        arvalid_q && !i_axil.arready |=> arvalid_q && $stable(addr_q));

endmodule

// ==== hdl/bridge_pkg.sv ====
// Shared widths, sideband bit positions, opcode and response enums, flit, request and AXI-Lite structs
package bridge_pkg;

    // **************************************************
    // Widths
    // **************************************************
    localparam int FLIT_W = 80;        // PHY word in register mode, two 40-bit halves
    localparam int ADDR_W = 32;        // AXI-Lite address
    localparam int DATA_W = 32;        // AXI-Lite data
    localparam int STRB_W = 4;         // One strobe per data byte
    localparam int OP_W   = 3;         // Opcode field
    localparam int RESP_W = 2;         // AXI response code

    // Spare bits left over in each flit format
    localparam int RX_PAD_W = FLIT_W - OP_W - STRB_W - ADDR_W - DATA_W;   // 9
    localparam int TX_PAD_W = FLIT_W - OP_W - RESP_W - DATA_W;            // 43

    // **************************************************
    // Sideband layout
    // **************************************************
    localparam int MS_SSR_LEN        = 81;   // Leader sideband length
    localparam int SL_SSR_LEN        = 73;   // Follower sideband length
    localparam int SL_TX_XFER_EN_BIT = 64;   // Follower tx transfer enable
    localparam int MS_TX_XFER_EN_BIT = 78;   // Leader tx transfer enable

    // Flit opcodes, shared by both directions
    typedef enum logic [OP_W-1:0] {
        OP_IDLE    = 3'd0,   // Empty slot
        OP_WRITE   = 3'd1,   // Write request from far side
        OP_READ    = 3'd2,   // Read request from far side
        OP_WR_RESP = 3'd3,   // Write completion back to far side
        OP_RD_RESP = 3'd4    // Read completion with data
    } opcode_e;

    // AXI response codes in use
    typedef enum logic [RESP_W-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // **************************************************
    // Flits and requests
    // **************************************************
    typedef struct packed {
        opcode_e             opcode;   // Top bits of the word
        logic [STRB_W-1:0]   strb;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
        logic [RX_PAD_W-1:0] pad;      // Unused by this bridge
    } rx_flit_t;

    typedef struct packed {
        logic                write;    // 1 write, 0 read
        logic [STRB_W-1:0]   strb;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } req_t;

    typedef struct packed {
        opcode_e             opcode;
        axi_resp_e           resp;
        logic [DATA_W-1:0]   rdata;    // Zero on write completions
        logic [TX_PAD_W-1:0] pad;
    } tx_flit_t;

    // Master driven AXI-Lite signals
    typedef struct packed {
        logic [ADDR_W-1:0] awaddr;
        logic              awvalid;
        logic [ADDR_W-1:0] araddr;
        logic              arvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              wvalid;
        logic              bready;
        logic              rready;
    } axil_req_t;

    // Slave driven AXI-Lite signals
    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              arready;
        logic              bvalid;
        axi_resp_e         bresp;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        axi_resp_e         rresp;
    } axil_rsp_t;

endpackage

// ==== hdl/flit_decoder.sv ====
// Link status gating and decode of AIB receive words into queued requests
`timescale 1ns/10ps

module flit_decoder (
    input  logic                               i_clk_wr,
    input  logic                               i_rst,
    input  bridge_pkg::rx_flit_t               i_rx_flit,      // One word per cycle from PHY
    input  logic [bridge_pkg::SL_SSR_LEN-1:0]  i_sl_sideband,  // Follower sideband levels
    input  logic [bridge_pkg::MS_SSR_LEN-1:0]  i_ms_sideband,  // Leader sideband levels
    output logic                               o_push,         // Request valid toward FIFO
    output bridge_pkg::req_t                   o_req
);

    // **************************************************
    // Link status
    // **************************************************
    logic sl_tx_xfer_en;   // Follower side ready to transfer
    logic ms_tx_xfer_en;   // Leader side ready to transfer
    logic link_online;
    logic is_req;          // Word carries a write or read

    assign sl_tx_xfer_en = i_sl_sideband[bridge_pkg::SL_TX_XFER_EN_BIT];
    assign ms_tx_xfer_en = i_ms_sideband[bridge_pkg::MS_TX_XFER_EN_BIT];
    assign link_online   = sl_tx_xfer_en & ms_tx_xfer_en;   // Both ends must agree

    // Idle slots and unknown codes fall through
    assign is_req = (i_rx_flit.opcode == bridge_pkg::OP_WRITE) ||
                    (i_rx_flit.opcode == bridge_pkg::OP_READ);

    // **************************************************
    // Request register
    // **************************************************
    always_ff @(posedge i_clk_wr) begin
        if (i_rst) begin
            o_push <= 1'b0;
        end else begin
            o_push <= is_req & link_online;   // Offline words are lost here
        end
    end

    // Payload follows the word every cycle
    always_ff @(posedge i_clk_wr) begin
        o_req.write <= (i_rx_flit.opcode == bridge_pkg::OP_WRITE);
        o_req.strb  <= i_rx_flit.strb;
        o_req.addr  <= i_rx_flit.addr;
        o_req.data  <= i_rx_flit.wdata;   // Don't care for reads
    end

    // **************************************************
    // Checks
    // **************************************************
    // Far side is a leader and never sends completions
    a_no_resp_opcode: assert property (@(posedge i_clk_wr) disable iff (i_rst)
        !(i_rx_flit.opcode inside {bridge_pkg::OP_WR_RESP, bridge_pkg::OP_RD_RESP}));

endmodule

// ==== hdl/req_fifo.sv ====
// Parameterised circular request queue with occupancy count and overflow guard
`timescale 1ns/10ps

module req_fifo #(
    parameter int FIFO_DEPTH = 4                 // Power of two, 2 to 16
) (
    input  logic             i_clk_wr,
    input  logic             i_rst,
    input  logic             i_push,             // From decoder
    input  logic             i_pop,              // From AXI-Lite engine
    input  bridge_pkg::req_t i_req,
    output bridge_pkg::req_t o_req,              // Head entry
    output logic             o_not_empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);   // Wraps naturally at depth
    localparam int CNT_W = PTR_W + 1;            // Holds 0 to FIFO_DEPTH

    // **************************************************
    // Storage and pointers
    // **************************************************
    bridge_pkg::req_t   mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    assign full        = (count == CNT_W'(FIFO_DEPTH));
    assign o_not_empty = (count != '0);
    assign wr_en       = i_push & ~full;          // Drop instead of corrupting
    assign rd_en       = i_pop & o_not_empty;

    // Head is read straight from the array
    assign o_req = mem[rd_ptr];

    always_ff @(posedge i_clk_wr) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_req;
        end
    end

    // Pointer and occupancy update
    always_ff @(posedge i_clk_wr) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);   // Push only
                2'b01:   count <= count - CNT_W'(1);   // Pop only
                default: count <= count;               // Both or neither
            endcase
        end
    end

    // **************************************************
    // Credit contract
    // **************************************************
    // Far side holds at most FIFO_DEPTH credits
    a_no_overflow: assert property (@(posedge i_clk_wr) disable iff (i_rst)
        !(i_push && full));

    // Consumer only pops a valid head
    a_no_underflow: assert property (@(posedge i_clk_wr) disable iff (i_rst)
        !(i_pop && !o_not_empty));

endmodule
